// ==== src/mipsPkg.sv ====
//////////////////////////////////////////////////////////////////////
// mips package
// widths, opcodes, function codes and the structs shared by the core
//////////////////////////////////////////////////////////////////////
package mipsPkg;

	localparam int dataWidth = 16;
	localparam int regAddrWidth = 3;
	localparam int memDepth = 256;
	localparam int memAddrWidth = $clog2(memDepth);
	localparam int linkReg = 7;
	localparam int immWidth = 7;
	localparam int targetWidth = 13;

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [regAddrWidth-1:0] regIdx_t;

	// instruction bits 15 to 13
	typedef enum logic [2:0] {
		opRType = 3'd0,
		opSlti = 3'd1,
		opJ = 3'd2,
		opJal = 3'd3,
		opLw = 3'd4,
		opSw = 3'd5,
		opBeq = 3'd6,
		opAddi = 3'd7
	} opcode_e;

	// r-type function, bits 3 to 0
	typedef enum logic [3:0] {
		fnAdd = 4'd0,
		fnSub = 4'd1,
		fnAnd = 4'd2,
		fnOr = 4'd3,
		fnSlt = 4'd4,
		fnJr = 4'd8
	} funct_e;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOp_e;

	typedef enum logic [1:0] {
		dstRt,
		dstRd,
		dstLink
	} destSel_e;

	typedef enum logic [1:0] {
		resAlu,
		resMem,
		resPc
	} resultSel_e;

	typedef struct packed {
		destSel_e destSel;
		resultSel_e resultSel;
		aluOp_e aluOp;
		logic aluSrcImm;
		logic branch;
		logic jump;
		logic jumpReg;
		logic memRead;
		logic memWrite;
		logic regWrite;
	} ctrl_t;

	typedef struct packed {
		regIdx_t rs;
		regIdx_t rt;
		regIdx_t dest;
		word_t imm;
		logic [targetWidth-1:0] jumpTarget;
	} decoded_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic read;
		logic write;
	} memReq_t;

	// one register write per retired instruction
	typedef struct packed {
		logic valid;
		regIdx_t dest;
		word_t data;
	} commit_t;

endpackage

// ==== src/fetchUnit.sv ====
//////////////////////////////////////////////////////////////////////
// fetch unit
// program counter and next-pc selection
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module fetchUnit (
	input logic clk,
	input logic reset,
	input mipsPkg::ctrl_t ctrl,
	input mipsPkg::decoded_t dec,
	input logic zero,
	input mipsPkg::word_t rsData,
	output mipsPkg::word_t instrAddr,
	output mipsPkg::word_t pcPlus2
);
	import mipsPkg::*;

	word_t pc;
	word_t nextPc;
	word_t branchTarget;
	word_t jumpTarget;

	assign pcPlus2 = pc + word_t'(2);

	// immediate counts instructions, so shift by one for bytes
	assign branchTarget = pcPlus2 + {dec.imm[dataWidth-2:0], 1'b0};

	// region bits come from pc+2
	assign jumpTarget = {pcPlus2[dataWidth-1 -: 2], dec.jumpTarget, 1'b0};

	always_comb begin
		if (ctrl.jumpReg) begin
			nextPc = rsData;
		end else if (ctrl.jump) begin
			nextPc = jumpTarget;
		end else if (ctrl.branch && zero) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pcPlus2;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= nextPc;
		end
	end

	assign instrAddr = pc;

	// jr targets come from the register file, so this also checks software
	pcEven: assert property (@(posedge clk) disable iff (reset) !instrAddr[0])
		else $error("odd pc %h", instrAddr);

endmodule

// ==== src/controlDecoder.sv ====
//////////////////////////////////////////////////////////////////////
// control decoder
// instruction fields, control bundle and extended immediate
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module controlDecoder (
	input logic reset,
	input mipsPkg::word_t instr,
	output mipsPkg::ctrl_t ctrl,
	output mipsPkg::decoded_t dec
);
	import mipsPkg::*;

	opcode_e opcode;
	funct_e funct;
	logic signExt;

	assign opcode = opcode_e'(instr[15:13]);
	assign funct = funct_e'(instr[3:0]);

	always_comb begin
		ctrl = '0;
		ctrl.destSel = dstRt;
		ctrl.resultSel = resAlu;
		ctrl.aluOp = aluAdd;
		signExt = 1'b1;
		// held in reset the bundle stays inert, so nothing commits
		if (!reset) begin
			case (opcode)
				opRType: begin
					ctrl.destSel = dstRd;
					ctrl.regWrite = 1'b1;
					case (funct)
						fnSub: ctrl.aluOp = aluSub;
						fnAnd: ctrl.aluOp = aluAnd;
						fnOr: ctrl.aluOp = aluOr;
						fnSlt: ctrl.aluOp = aluSlt;
						fnJr: begin
							ctrl.jumpReg = 1'b1;
							ctrl.regWrite = 1'b0;
						end
						// unlisted codes run as add
						default: ctrl.aluOp = aluAdd;
					endcase
				end
				opSlti: begin
					ctrl.aluOp = aluSlt;
					ctrl.aluSrcImm = 1'b1;
					ctrl.regWrite = 1'b1;
					signExt = 1'b0;
				end
				opJ: begin
					ctrl.jump = 1'b1;
				end
				opJal: begin
					ctrl.jump = 1'b1;
					ctrl.destSel = dstLink;
					ctrl.resultSel = resPc;
					ctrl.regWrite = 1'b1;
				end
				opLw: begin
					ctrl.aluSrcImm = 1'b1;
					ctrl.memRead = 1'b1;
					ctrl.resultSel = resMem;
					ctrl.regWrite = 1'b1;
				end
				opSw: begin
					ctrl.aluSrcImm = 1'b1;
					ctrl.memWrite = 1'b1;
				end
				opBeq: begin
					ctrl.branch = 1'b1;
					ctrl.aluOp = aluSub;
				end
				opAddi: begin
					ctrl.aluSrcImm = 1'b1;
					ctrl.regWrite = 1'b1;
				end
			endcase
		end
	end

	always_comb begin
		dec.rs = instr[12:10];
		dec.rt = instr[9:7];
		case (ctrl.destSel)
			dstRd: dec.dest = instr[6:4];
			dstLink: dec.dest = regIdx_t'(linkReg);
			default: dec.dest = instr[9:7];
		endcase
		if (signExt) begin
			dec.imm = {{(dataWidth-immWidth){instr[immWidth-1]}}, instr[immWidth-1:0]};
		end else begin
			dec.imm = {{(dataWidth-immWidth){1'b0}}, instr[immWidth-1:0]};
		end
		dec.jumpTarget = instr[targetWidth-1:0];
	end

endmodule

// ==== src/registerFile.sv ====
//////////////////////////////////////////////////////////////////////
// register file
// eight registers, two read ports, written from the commit record
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module registerFile (
	input logic clk,
	input logic reset,
	input mipsPkg::regIdx_t rsIdx,
	input mipsPkg::regIdx_t rtIdx,
	input mipsPkg::commit_t commit,
	output mipsPkg::word_t rsData,
	output mipsPkg::word_t rtData
);
	import mipsPkg::*;

	word_t regs [2**regAddrWidth];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 2**regAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (commit.valid) begin
			regs[commit.dest] <= commit.data;
		end
	end

	// register 0 is hardwired
	assign rsData = (rsIdx == '0) ? '0 : regs[rsIdx];
	assign rtData = (rtIdx == '0) ? '0 : regs[rtIdx];

	// write-back must already have filtered out register 0
	noZeroCommit: assert property (@(posedge clk) disable iff (reset)
		commit.valid |-> commit.dest != '0)
		else $error("commit to register 0");

endmodule

// ==== src/executeUnit.sv ====
//////////////////////////////////////////////////////////////////////
// execute unit
// operand select, alu and memory request
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module executeUnit (
	input mipsPkg::ctrl_t ctrl,
	input mipsPkg::decoded_t dec,
	input mipsPkg::word_t rsData,
	input mipsPkg::word_t rtData,
	output mipsPkg::word_t aluResult,
	output logic zero,
	output mipsPkg::memReq_t memReq
);
	import mipsPkg::*;

	word_t opB;

	assign opB = ctrl.aluSrcImm ? dec.imm : rtData;

	always_comb begin
		case (ctrl.aluOp)
			aluSub: aluResult = rsData - opB;
			aluAnd: aluResult = rsData & opB;
			aluOr: aluResult = rsData | opB;
			// unsigned compare
			aluSlt: aluResult = (rsData < opB) ? word_t'(1) : '0;
			default: aluResult = rsData + opB;
		endcase
	end

	assign zero = (aluResult == '0);

	// address is base plus offset, store data is rt
	always_comb begin
		memReq.addr = aluResult;
		memReq.wdata = rtData;
		memReq.read = ctrl.memRead;
		memReq.write = ctrl.memWrite;
	end

endmodule

// ==== src/memWriteback.sv ====
//////////////////////////////////////////////////////////////////////
// memory and write-back
// data memory and the commit record for the register write
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module memWriteback (
	input logic clk,
	input mipsPkg::ctrl_t ctrl,
	input mipsPkg::decoded_t dec,
	input mipsPkg::memReq_t memReq,
	input mipsPkg::word_t aluResult,
	input mipsPkg::word_t pcPlus2,
	output mipsPkg::commit_t commit
);
	import mipsPkg::*;

	word_t mem [memDepth];
	logic [memAddrWidth-1:0] wordAddr;
	word_t readData;
	word_t wbData;

	initial begin
		for (int i = 0; i < memDepth; i++) begin
			mem[i] = '0;
		end
	end

	// byte address, one word per two bytes
	assign wordAddr = memReq.addr[memAddrWidth:1];

	always_ff @(posedge clk) begin
		if (memReq.write) begin
			mem[wordAddr] <= memReq.wdata;
		end
	end

	assign readData = memReq.read ? mem[wordAddr] : '0;

	always_comb begin
		case (ctrl.resultSel)
			resMem: wbData = readData;
			resPc: wbData = pcPlus2;
			default: wbData = aluResult;
		endcase
	end

	always_comb begin
		commit.valid = ctrl.regWrite && (dec.dest != '0);
		commit.dest = dec.dest;
		commit.data = wbData;
	end

endmodule

// ==== src/mipsCore.sv ====
//////////////////////////////////////////////////////////////////////
// mips core
// single-cycle 16-bit core, instruction memory outside
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mipsCore (
	input logic clk,
	input logic reset,
	input mipsPkg::word_t instr,
	output mipsPkg::word_t instrAddr,
	output mipsPkg::commit_t commit
);
	import mipsPkg::*;

	ctrl_t ctrl;
	decoded_t dec;
	word_t pcPlus2;
	word_t rsData;
	word_t rtData;
	word_t aluResult;
	logic zero;
	memReq_t memReq;

	fetchUnit fetch (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.dec(dec),
		.zero(zero),
		.rsData(rsData),
		.instrAddr(instrAddr),
		.pcPlus2(pcPlus2)
	);

	controlDecoder decode (
		.reset(reset),
		.instr(instr),
		.ctrl(ctrl),
		.dec(dec)
	);

	// write port closes the loop from write-back
	registerFile regFile (
		.clk(clk),
		.reset(reset),
		.rsIdx(dec.rs),
		.rtIdx(dec.rt),
		.commit(commit),
		.rsData(rsData),
		.rtData(rtData)
	);

	executeUnit execute (
		.ctrl(ctrl),
		.dec(dec),
		.rsData(rsData),
		.rtData(rtData),
		.aluResult(aluResult),
		.zero(zero),
		.memReq(memReq)
	);

	memWriteback memWb (
		.clk(clk),
		.ctrl(ctrl),
		.dec(dec),
		.memReq(memReq),
		.aluResult(aluResult),
		.pcPlus2(pcPlus2),
		.commit(commit)
	);

endmodule

// ==== include/mipsAsm.svh ====
//////////////////////////////////////////////////////////////////////
// instruction encoders for the testbench
// one function per instruction format
//////////////////////////////////////////////////////////////////////
`ifndef MIPS_ASM_SVH
`define MIPS_ASM_SVH

// r-type: opcode, rs, rt, rd, funct
function automatic mipsPkg::word_t encR(
	input mipsPkg::funct_e funct,
	input mipsPkg::regIdx_t rd,
	input mipsPkg::regIdx_t rs,
	input mipsPkg::regIdx_t rt
);
	mipsPkg::word_t w;
	w = {mipsPkg::opRType, rs, rt, rd, funct};
	return w;
endfunction

// i-type: 7-bit immediate in the low bits
function automatic mipsPkg::word_t encI(
	input mipsPkg::opcode_e op,
	input mipsPkg::regIdx_t rt,
	input mipsPkg::regIdx_t rs,
	input logic [mipsPkg::immWidth-1:0] imm
);
	mipsPkg::word_t w;
	w = {op, rs, rt, imm};
	return w;
endfunction

// j-type: target is a word index, the core shifts it left by one
function automatic mipsPkg::word_t encJ(
	input mipsPkg::opcode_e op,
	input logic [mipsPkg::targetWidth-1:0] target
);
	mipsPkg::word_t w;
	w = {op, target};
	return w;
endfunction

`endif

// ==== verification/tbMips.sv ====
//////////////////////////////////////////////////////////////////////
// mips core testbench
// instruction rom, reference model and commit-by-commit checking
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tbMips;
	import mipsPkg::*;

	`include "mipsAsm.svh"

	localparam int romDepth = 512;
	localparam int randomCount = 200;
	localparam int runLimit = 4000;

	typedef struct packed {
		commit_t commit;
		word_t nextPc;
	} stepResult_t;

	logic clk = 1'b0;
	logic reset;
	word_t instr;
	word_t instrAddr;
	commit_t commit;

	word_t rom [romDepth];
	word_t refRegs [8];
	word_t refMem [memDepth];
	word_t refPc;
	stepResult_t expected;
	int nextSlot;
	int endIdx;
	int checked;
	int cycles;
	integer seed;

	mipsCore dut (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrAddr(instrAddr),
		.commit(commit)
	);

	always #2 clk = ~clk;

	// rom read, word index from the byte address
	always @(negedge clk) begin
		instr <= rom[instrAddr[9:1]];
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkAddr(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			abortRun($sformatf("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time));
		end
	endtask

	task automatic checkCommit(input commit_t got, input commit_t exp);
		if (got.valid !== exp.valid) begin
			abortRun($sformatf("[FAIL] commit.valid got %h expected %h at %0t",
				got.valid, exp.valid, $time));
		end else if (exp.valid && (got.dest !== exp.dest || got.data !== exp.data)) begin
			abortRun($sformatf("[FAIL] commit got dest %h data %h expected dest %h data %h at %0t",
				got.dest, got.data, exp.dest, exp.data, $time));
		end
	endtask

	// one architectural step, updates the model registers and memory
	function automatic stepResult_t stepModel(input word_t w);
		stepResult_t r;
		word_t a;
		word_t b;
		word_t seImm;
		word_t zeImm;
		word_t seqPc;
		word_t wrData;
		regIdx_t wrDest;
		logic wrEn;
		logic [7:0] memIdx;
		a = refRegs[w[12:10]];
		b = refRegs[w[9:7]];
		seImm = {{9{w[6]}}, w[6:0]};
		zeImm = {9'b0, w[6:0]};
		seqPc = refPc + 16'd2;
		r.nextPc = seqPc;
		wrEn = 1'b0;
		wrDest = w[9:7];
		wrData = '0;
		// memory index wraps to the low 256 words
		memIdx = 8'((a + seImm) >> 1);
		case (opcode_e'(w[15:13]))
			opRType: begin
				wrEn = 1'b1;
				wrDest = w[6:4];
				case (w[3:0])
					4'd1: wrData = a - b;
					4'd2: wrData = a & b;
					4'd3: wrData = a | b;
					4'd4: wrData = {15'b0, a < b};
					4'd8: begin
						wrEn = 1'b0;
						r.nextPc = a;
					end
					default: wrData = a + b;
				endcase
			end
			opSlti: begin
				wrEn = 1'b1;
				wrData = {15'b0, a < zeImm};
			end
			opAddi: begin
				wrEn = 1'b1;
				wrData = a + seImm;
			end
			opLw: begin
				wrEn = 1'b1;
				wrData = refMem[memIdx];
			end
			opSw: refMem[memIdx] = b;
			opBeq: begin
				if (a == b) r.nextPc = seqPc + {seImm[14:0], 1'b0};
			end
			opJal: begin
				wrEn = 1'b1;
				wrDest = 3'd7;
				wrData = seqPc;
				r.nextPc = {seqPc[15:14], w[12:0], 1'b0};
			end
			default: r.nextPc = {seqPc[15:14], w[12:0], 1'b0};
		endcase
		r.commit.valid = wrEn && (wrDest != 3'd0);
		r.commit.dest = wrDest;
		r.commit.data = wrData;
		if (r.commit.valid) refRegs[wrDest] = wrData;
		return r;
	endfunction

	task automatic put(input word_t w);
		rom[nextSlot] = w;
		nextSlot++;
	endtask

	task automatic buildProgram();
		int loopIdx;
		int r;
		regIdx_t rd;
		regIdx_t rs;
		regIdx_t rt;
		logic [6:0] imm;
		// every unused word jumps to itself
		for (int i = 0; i < romDepth; i++) rom[i] = encJ(opJ, 13'(i));
		nextSlot = 0;
		put(encI(opAddi, 3'd1, 3'd0, 7'd5));
		// -3
		put(encI(opAddi, 3'd2, 3'd0, 7'h7D));
		put(encR(fnAdd, 3'd3, 3'd1, 3'd2));
		put(encR(fnSub, 3'd4, 3'd1, 3'd2));
		put(encR(fnAnd, 3'd5, 3'd1, 3'd2));
		put(encR(fnOr, 3'd6, 3'd1, 3'd2));
		put(encR(fnSlt, 3'd5, 3'd1, 3'd2));
		put(encI(opAddi, 3'd7, 3'd0, 7'd63));
		put(encR(fnAdd, 3'd7, 3'd7, 3'd7));
		// 126 stays above 64 unless the immediate is sign-extended
		put(encI(opSlti, 3'd6, 3'd7, 7'h40));
		put(encI(opSlti, 3'd6, 3'd2, 7'h7F));
		// writes to register 0, then a read of it
		put(encI(opAddi, 3'd0, 3'd1, 7'd9));
		put(encR(fnAdd, 3'd0, 3'd1, 3'd1));
		put(encR(fnAdd, 3'd3, 3'd0, 3'd1));
		put(encI(opSw, 3'd1, 3'd0, 7'd0));
		put(encI(opSw, 3'd2, 3'd0, 7'd10));
		put(encI(opSw, 3'd4, 3'd4, 7'd20));
		put(encI(opSw, 3'd5, 3'd4, 7'h7E));
		put(encI(opLw, 3'd3, 3'd0, 7'd0));
		put(encI(opLw, 3'd5, 3'd0, 7'd10));
		put(encI(opLw, 3'd6, 3'd4, 7'd20));
		put(encI(opLw, 3'd5, 3'd4, 7'h7E));
		// never written
		put(encI(opLw, 3'd3, 3'd0, 7'd40));
		put(encI(opBeq, 3'd2, 3'd1, 7'd1));
		put(encI(opBeq, 3'd1, 3'd1, 7'd1));
		put(encI(opAddi, 3'd3, 3'd0, 7'd1));
		// three passes through a backward branch
		put(encR(fnAnd, 3'd5, 3'd0, 3'd0));
		loopIdx = nextSlot;
		put(encI(opAddi, 3'd5, 3'd5, 7'd1));
		put(encI(opSlti, 3'd6, 3'd5, 7'd3));
		put(encI(opBeq, 3'd0, 3'd6, 7'd1));
		put(encI(opBeq, 3'd0, 3'd0, 7'(loopIdx - nextSlot - 1)));
		put(encJ(opJ, 13'(nextSlot + 2)));
		put(encI(opAddi, 3'd3, 3'd0, 7'd2));
		// call, link check, skip over the subroutine
		put(encJ(opJal, 13'(nextSlot + 3)));
		put(encR(fnAdd, 3'd2, 3'd7, 3'd0));
		put(encJ(opJ, 13'(nextSlot + 3)));
		put(encI(opAddi, 3'd1, 3'd1, 7'd1));
		put(encR(fnJr, 3'd0, 3'd7, 3'd0));
		for (int k = 0; k < randomCount; k++) begin
			r = $random(seed);
			rd = r[6:4];
			rs = r[9:7];
			rt = r[12:10];
			imm = r[19:13];
			case (r[3:0] % 4'd9)
				4'd0: put(encR(fnAdd, rd, rs, rt));
				4'd1: put(encR(fnSub, rd, rs, rt));
				4'd2: put(encR(fnAnd, rd, rs, rt));
				4'd3: put(encR(fnOr, rd, rs, rt));
				4'd4: put(encR(fnSlt, rd, rs, rt));
				4'd5: put(encI(opAddi, rt, rs, imm));
				4'd6: put(encI(opSlti, rt, rs, imm));
				4'd7: put(encI(opLw, rt, rs, imm));
				default: put(encI(opSw, rt, rs, imm));
			endcase
		end
		endIdx = nextSlot;
		put(encJ(opJ, 13'(endIdx)));
	endtask

	// reference and DUT compared at every rising edge
	always @(posedge clk) begin
		if (reset) begin
			checkAddr("instrAddr", instrAddr, '0);
			checkCommit(commit, '0);
		end else begin
			checkAddr("instrAddr", instrAddr, refPc);
			expected = stepModel(instr);
			checkCommit(commit, expected.commit);
			refPc = expected.nextPc;
			checked++;
		end
	end

	initial begin
		reset = 1'b0;
		instr = '0;
		seed = 21;
		refPc = '0;
		checked = 0;
		for (int i = 0; i < 8; i++) refRegs[i] = '0;
		for (int i = 0; i < memDepth; i++) refMem[i] = '0;
		buildProgram();
		// async reset edge ahead of the first clock edge
		#1 reset = 1'b1;
		repeat (4) @(negedge clk);
		reset <= 1'b0;
		cycles = 0;
		while (instrAddr !== word_t'(endIdx * 2) && cycles < runLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (instrAddr !== word_t'(endIdx * 2)) begin
			abortRun("timeout: the program never reached its final jump");
		end
		repeat (3) @(negedge clk);
		if (checked < randomCount) begin
			abortRun("run ended after fewer instructions than the random program holds");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

// ==== all.f ====
+incdir+include
src/mipsPkg.sv
src/fetchUnit.sv
src/controlDecoder.sv
src/registerFile.sv
src/executeUnit.sv
src/memWriteback.sv
src/mipsCore.sv
verification/tbMips.sv

// ==== run.sh ====
#!/bin/sh
# build the mips testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/simTbMips

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tbMips -o simTbMips
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
	echo "simulation ended without a verdict"
	exit 1
fi
exit 0
